// File: verilog.f
verilog/cache_pkg.sv
verilog/bus_pkg.sv
verilog/cache_ram.sv
verilog/tag_lookup.sv
verilog/data_store.sv
verilog/cache_ctrl.sv
verilog/dcache_top.sv
tests/dcache_properties.sv
tests/dcache_tb.sv

// File: tests/dcache_tb.sv
`default_nettype none

module dcache_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int SETS       = 16;
  localparam int LINE_WORDS = 16;
  localparam int MEM_WORDS  = 4096;
  localparam int MAX_STALL  = 3;
  localparam int N_RANDOM   = 200;
  localparam int N_REQ      = N_RANDOM + 16;  // Directed part stays below 16
  localparam int TIMEOUT    = N_REQ * (2 * LINE_WORDS * (MAX_STALL + 1) + 10);

  logic              clk = 1'b0;
  logic              rst;
  bus_pkg::cpu_req_t cpu_req;
  bus_pkg::cpu_rsp_t cpu_rsp;
  bus_pkg::mem_req_t mem_req;
  bus_pkg::mem_rsp_t mem_rsp;

  cache_pkg::word_t mem    [MEM_WORDS];
  cache_pkg::word_t golden [MEM_WORDS];  // CPU view of memory
  int               errors     = 0;
  int               rsp_count  = 0;
  int               beat_count = 0;
  int               rd_bursts  = 0;
  int               wr_bursts  = 0;
  int               cycles     = 0;
  logic [31:0]      last_wb_addr;
  logic [31:0]      mem_seed   = 32'd7;
  logic [31:0]      stim_seed  = 32'd7;

  dcache_top #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_dut (
    .clk, .rst, .cpu_req, .cpu_rsp, .mem_req, .mem_rsp
  );

  bind cache_ctrl dcache_properties u_properties (
    .clk(clk), .rst(rst), .cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
    .mem_req(mem_req), .mem_rsp(mem_rsp)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Odd multiplier, so every word index gives its own pattern
  function automatic cache_pkg::word_t init_word(input int unsigned w);
    return 32'hC0DE_0000 ^ (w * 32'h9E37_79B1);
  endfunction

  function automatic cache_pkg::word_t ref_access(input bus_pkg::cpu_req_t req);
    int unsigned w;
    w = req.addr[13:2];
    if (req.write)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (req.be[b])
          golden[w][b*8 +: 8] = req.wdata[b*8 +: 8];
      end
    end
    return golden[w];
  endfunction

  task automatic random_stall();
    mem_seed = lcg_step(mem_seed);
    repeat ((mem_seed >> 16) % (MAX_STALL + 1)) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////

  always
  begin : memory_model
    int unsigned base;
    @(negedge clk);
    base = mem_req.addr[13:2];
    if (mem_req.wr)
    begin
      wr_bursts++;
      last_wb_addr = mem_req.addr;
      for (int i = 0; i < LINE_WORDS; i++)
      begin
        random_stall();
        if (mem_req.wdata !== golden[base + i])
        begin
          errors++;
          $display("ERROR at %0t: write-back of %h gave %h, expected %h",
                   $time, (base + i) * 4, mem_req.wdata, golden[base + i]);
        end
        mem[base + i] = mem_req.wdata;
        beat_count++;
        mem_rsp.wdata_ok = 1'b1;
        @(negedge clk);
        mem_rsp.wdata_ok = 1'b0;
      end
    end
    else if (mem_req.rd)
    begin
      rd_bursts++;
      random_stall();
      mem_rsp.addr_ok = 1'b1;
      @(negedge clk);
      mem_rsp.addr_ok = 1'b0;
      for (int i = 0; i < LINE_WORDS; i++)
      begin
        random_stall();
        mem_rsp.rdata    = mem[base + i];
        mem_rsp.rdata_ok = 1'b1;
        @(negedge clk);
        mem_rsp.rdata_ok = 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Response check and timeout
  ////////////////////////////////////////

  always @(negedge clk)
  begin : compare_rsp
    cache_pkg::word_t expected;
    if (cpu_rsp.ok)
    begin
      expected = ref_access(cpu_req);
      rsp_count++;
      if (cpu_rsp.rdata !== expected)
      begin
        errors++;
        $display("ERROR at %0t: access to %h returned %h, expected %h",
                 $time, cpu_req.addr, cpu_rsp.rdata, expected);
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("Test failures found");
      $finish;
    end
  end

  // Holds the request until ok, counts cycles to it
  task automatic cpu_access(input logic [31:0] addr, input logic write,
                            input cache_pkg::word_t wdata, input cache_pkg::be_t be,
                            output int lat);
    @(negedge clk);
    cpu_req = '{valid: 1'b1, write: write, addr: addr, wdata: wdata, be: be};
    lat     = 0;
    do
    begin
      @(negedge clk);
      lat++;
    end
    while (!cpu_rsp.ok);
  endtask

  // A hit expects no burst and a 2 cycle response
  task automatic expect_access(input logic [31:0] addr, input logic write,
                               input cache_pkg::word_t wdata, input cache_pkg::be_t be,
                               input int rd_n, input int wr_n);
    int rd0;
    int wr0;
    int lat;
    rd0 = rd_bursts;
    wr0 = wr_bursts;
    cpu_access(addr, write, wdata, be, lat);
    if ((rd_bursts - rd0 != rd_n) || (wr_bursts - wr0 != wr_n))
    begin
      errors++;
      $display("ERROR at %0t: access to %h made %0d reads and %0d write-backs, expected %0d and %0d",
               $time, addr, rd_bursts - rd0, wr_bursts - wr0, rd_n, wr_n);
    end
    if ((rd_n == 0) && (wr_n == 0) && (lat != 2))
    begin
      errors++;
      $display("ERROR at %0t: hit at %h took %0d cycles, expected 2", $time, addr, lat);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial
  begin : stimulus
    logic [31:0]      a;
    cache_pkg::word_t d;
    int               lat;
    rst     = 1'b1;
    cpu_req = '0;
    mem_rsp = '0;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      mem[i]    = init_word(i);
      golden[i] = init_word(i);
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    repeat (4)  // Quiet bus with no request
    begin
      @(negedge clk);
      if (cpu_rsp.ok || mem_req.rd || mem_req.wr)
      begin
        errors++;
        $display("ERROR at %0t: ok, rd or wr high with no request", $time);
      end
    end

    expect_access(32'h0000_0008, 1'b0, '0, '0, 1, 0);  // Line A, set 0
    expect_access(32'h0000_0014, 1'b0, '0, '0, 0, 0);
    expect_access(32'h0000_0008, 1'b1, 32'h1122_3344, 4'b0101, 0, 0);
    expect_access(32'h0000_0030, 1'b1, 32'hAABB_CCDD, 4'b1000, 0, 0);
    expect_access(32'h0000_0008, 1'b0, '0, '0, 0, 0);
    expect_access(32'h0000_0030, 1'b0, '0, '0, 0, 0);

    // B dirty, then C and D, A again, E takes B's way
    expect_access(32'h0000_0404, 1'b1, 32'hDEAD_BEEF, 4'b1111, 1, 0);
    expect_access(32'h0000_0800, 1'b0, '0, '0, 1, 0);
    expect_access(32'h0000_0C00, 1'b0, '0, '0, 1, 0);
    expect_access(32'h0000_0000, 1'b0, '0, '0, 0, 0);
    expect_access(32'h0000_1000, 1'b0, '0, '0, 1, 1);
    if (last_wb_addr !== 32'h0000_0400)
    begin
      errors++;
      $display("ERROR at %0t: victim line %h written back, expected 00000400",
               $time, last_wb_addr);
    end
    expect_access(32'h0000_003C, 1'b0, '0, '0, 0, 0);
    expect_access(32'h0000_0404, 1'b0, '0, '0, 1, 0);

    // Six tags over sets 0 and 1
    for (int n = 0; n < N_RANDOM; n++)
    begin
      stim_seed = lcg_step(stim_seed);
      a = (((stim_seed >> 24) % 6) << 10) | (((stim_seed >> 20) & 1) << 6)
        | (((stim_seed >> 16) & 15) << 2);
      d = lcg_step(stim_seed);
      cpu_access(a, stim_seed[30], d, stim_seed[15:12], lat);
    end

    @(negedge clk);
    cpu_req = '0;
    repeat (2) @(negedge clk);
    $display("Checked %0d responses and %0d write-back beats, %0d errors",
             rsp_count, beat_count, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/dcache_properties.sv
`default_nettype none

module dcache_properties (
  input logic              clk,
  input logic              rst,
  input bus_pkg::cpu_req_t cpu_req,
  input bus_pkg::cpu_rsp_t cpu_rsp,
  input bus_pkg::mem_req_t mem_req,
  input bus_pkg::mem_rsp_t mem_rsp
);

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////
  // Controller rules
  ////////////////////////////////////////

  ok_with_request: assert property (
    @(posedge clk) disable iff (rst) cpu_rsp.ok |-> cpu_req.valid
  ) else $error("ok high without a valid request");

  // Write-back ends before the refill starts
  rd_wr_exclusive: assert property (
    @(posedge clk) disable iff (rst)
    mem_req.rd |-> !mem_req.wr && !$past(mem_req.wr && !mem_rsp.wdata_ok)
  ) else $error("rd raised while a write-back beat was still pending");

  rd_addr_stable: assert property (
    @(posedge clk) disable iff (rst)
    (mem_req.rd && !mem_rsp.addr_ok) |=> $stable(mem_req.addr)
  ) else $error("burst address changed while rd waited for addr_ok");

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
`default_nettype none

module dcache_top #(
  parameter int SETS       = 16,
  parameter int LINE_WORDS = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::cpu_req_t cpu_req,
  output bus_pkg::cpu_rsp_t cpu_rsp,
  output bus_pkg::mem_req_t mem_req,
  input  bus_pkg::mem_rsp_t mem_rsp
);

  localparam int IDX_BITS = $clog2(SETS);
  localparam int TAG_BITS = cache_pkg::ADDR_BITS - IDX_BITS - $clog2(LINE_WORDS) - 2;

  logic [IDX_BITS-1:0]                  index;
  logic [TAG_BITS-1:0]                  lookup_tag;
  logic [TAG_BITS-1:0]                  victim_tag;
  cache_pkg::way_t                      fill_way;
  cache_pkg::way_t                      use_way;
  cache_pkg::way_t                      victim_way;
  logic                                 fill_en;
  logic                                 use_en;
  logic                                 mark_dirty;
  logic                                 victim_dirty;
  cache_pkg::way_mask_t                 hit_mask;
  logic [$clog2(SETS*LINE_WORDS)-1:0]   word_addr;
  cache_pkg::word_t                     store_wdata;
  cache_pkg::way_mask_t                 store_we;
  cache_pkg::word_t                     store_rdata [cache_pkg::WAYS];

  tag_lookup #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_tag_lookup (
    .clk, .rst, .index, .lookup_tag, .fill_way, .fill_en, .use_way, .use_en,
    .mark_dirty, .hit_mask, .victim_way, .victim_tag, .victim_dirty
  );

  data_store #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_data_store (
    .clk, .word_addr, .wdata(store_wdata), .we(store_we), .rdata(store_rdata)
  );

  cache_ctrl #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_cache_ctrl (
    .clk, .rst, .cpu_req, .cpu_rsp, .mem_req, .mem_rsp,
    .index, .lookup_tag, .fill_way, .fill_en, .use_way, .use_en, .mark_dirty,
    .hit_mask, .victim_way, .victim_tag, .victim_dirty,
    .word_addr, .store_wdata, .store_we, .store_rdata
  );

endmodule

`default_nettype wire

// File: verilog/cache_ctrl.sv
`default_nettype none

module cache_ctrl #(
  parameter int SETS       = 16,
  parameter int LINE_WORDS = 16
) (
  input  logic                                clk,
  input  logic                                rst,
  input  bus_pkg::cpu_req_t                   cpu_req,
  output bus_pkg::cpu_rsp_t                   cpu_rsp,
  output bus_pkg::mem_req_t                   mem_req,
  input  bus_pkg::mem_rsp_t                   mem_rsp,
  output logic [$clog2(SETS)-1:0]             index,
  output logic [cache_pkg::ADDR_BITS-$clog2(SETS)-$clog2(LINE_WORDS)-3:0] lookup_tag,
  output cache_pkg::way_t                     fill_way,
  output logic                                fill_en,
  output cache_pkg::way_t                     use_way,
  output logic                                use_en,
  output logic                                mark_dirty,
  input  cache_pkg::way_mask_t                hit_mask,
  input  cache_pkg::way_t                     victim_way,
  input  logic [cache_pkg::ADDR_BITS-$clog2(SETS)-$clog2(LINE_WORDS)-3:0] victim_tag,
  input  logic                                victim_dirty,
  output logic [$clog2(SETS*LINE_WORDS)-1:0]  word_addr,
  output cache_pkg::word_t                    store_wdata,
  output cache_pkg::way_mask_t                store_we,
  input  cache_pkg::word_t                    store_rdata [cache_pkg::WAYS]
);

  localparam int IDX_BITS = $clog2(SETS);
  localparam int OFF_BITS = $clog2(LINE_WORDS);
  localparam int TAG_BITS = cache_pkg::ADDR_BITS - IDX_BITS - OFF_BITS - 2;

  typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, REFILL, REPLAY} state_t;

  state_t              state;
  logic [OFF_BITS-1:0] cnt;
  logic                phase;       // WB word primed, or refill address taken
  logic                ok_q;
  cache_pkg::word_t    rdata_q;
  cache_pkg::way_t     vic_way;
  logic [TAG_BITS-1:0] vic_tag;

  logic [IDX_BITS-1:0] req_idx;
  logic [OFF_BITS-1:0] req_off;
  logic                hit;
  cache_pkg::way_t     hit_way;
  cache_pkg::word_t    hit_word;
  cache_pkg::word_t    merged;
  logic                wb_accept;
  logic                rf_beat;
  logic                last;

  assign lookup_tag = cpu_req.addr[cache_pkg::ADDR_BITS-1 -: TAG_BITS];
  assign req_idx    = cpu_req.addr[OFF_BITS+2 +: IDX_BITS];
  assign req_off    = cpu_req.addr[2 +: OFF_BITS];
  assign index      = req_idx;

  ////////////////////////////////////////
  // Hit select and byte merge
  ////////////////////////////////////////

  assign hit = |hit_mask;

  always_comb
  begin
    hit_way = '0;
    for (int w = 0; w < cache_pkg::WAYS; w++)
    begin
      if (hit_mask[w])
        hit_way = cache_pkg::way_t'(w);
    end
  end

  assign hit_word = store_rdata[hit_way];

  always_comb
  begin
    for (int b = 0; b < cache_pkg::WORD_BITS/8; b++)
      merged[b*8 +: 8] = cpu_req.be[b] ? cpu_req.wdata[b*8 +: 8] : hit_word[b*8 +: 8];
  end

  ////////////////////////////////////////
  // Burst control
  ////////////////////////////////////////

  assign wb_accept = (state == WRITEBACK) && phase && mem_rsp.wdata_ok;
  assign rf_beat   = (state == REFILL) && phase && mem_rsp.rdata_ok;
  assign last      = (cnt == OFF_BITS'(LINE_WORDS - 1));

  // Writeback reads ahead so the next word is ready after each beat
  always_comb
  begin
    case (state)
      WRITEBACK: word_addr = {req_idx, wb_accept ? cnt + 1'b1 : cnt};
      REFILL:    word_addr = {req_idx, cnt};
      default:   word_addr = {req_idx, req_off};
    endcase
  end

  assign store_wdata = (state == REFILL) ? mem_rsp.rdata : merged;
  assign store_we    = rf_beat ? (cache_pkg::way_mask_t'(1) << vic_way)
                     : ((state == LOOKUP) && cpu_req.write) ? hit_mask : '0;

  assign use_en     = (state == LOOKUP) && hit;
  assign use_way    = hit_way;
  assign mark_dirty = cpu_req.write;
  assign fill_en    = rf_beat && last;
  assign fill_way   = vic_way;

  assign mem_req.rd    = (state == REFILL) && !phase;
  assign mem_req.wr    = (state == WRITEBACK) && phase;
  assign mem_req.addr  = (state == WRITEBACK) ? {vic_tag, req_idx, (OFF_BITS + 2)'(0)}
                                              : {lookup_tag, req_idx, (OFF_BITS + 2)'(0)};
  assign mem_req.wdata = store_rdata[vic_way];

  assign cpu_rsp.ok    = ok_q;
  assign cpu_rsp.rdata = rdata_q;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= IDLE;
      cnt   <= '0;
      phase <= 1'b0;
      ok_q  <= 1'b0;
    end
    else
    begin
      ok_q <= 1'b0;
      case (state)
        IDLE:
        begin
          if (cpu_req.valid && !ok_q)  // Skip the request just answered
            state <= LOOKUP;
        end
        LOOKUP:
        begin
          cnt   <= '0;
          phase <= 1'b0;
          if (hit)
          begin
            ok_q  <= 1'b1;
            state <= IDLE;
          end
          else
            state <= victim_dirty ? WRITEBACK : REFILL;
        end
        WRITEBACK:
        begin
          if (!phase)
            phase <= 1'b1;
          else if (wb_accept)
          begin
            cnt <= cnt + 1'b1;
            if (last)
            begin
              phase <= 1'b0;
              state <= REFILL;
            end
          end
        end
        REFILL:
        begin
          if (!phase)
            phase <= mem_rsp.addr_ok;
          else if (rf_beat)
          begin
            cnt <= cnt + 1'b1;
            if (last)
              state <= REPLAY;
          end
        end
        REPLAY:  state <= LOOKUP;  // Re-read, then respond as a hit
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == LOOKUP) && hit)
      rdata_q <= cpu_req.write ? merged : hit_word;
    if ((state == LOOKUP) && !hit)
    begin
      vic_way <= victim_way;
      vic_tag <= victim_tag;
    end
  end

endmodule

`default_nettype wire

// File: verilog/data_store.sv
`default_nettype none

module data_store #(
  parameter int SETS       = 16,
  parameter int LINE_WORDS = 16
) (
  input  logic                                   clk,
  input  logic [$clog2(SETS*LINE_WORDS)-1:0]     word_addr,
  input  cache_pkg::word_t                       wdata,
  input  cache_pkg::way_mask_t                   we,
  output cache_pkg::word_t                       rdata [cache_pkg::WAYS]
);

  localparam int DEPTH = SETS * LINE_WORDS;

  ////////////////////////////////////////
  // One data RAM per way
  ////////////////////////////////////////

  // Set and offset address every way at once
  for (genvar w = 0; w < cache_pkg::WAYS; w++)
  begin : g_way
    cache_ram #(
      .DEPTH   (DEPTH),
      .ENTRY_T (cache_pkg::word_t)
    ) u_data_ram (
      .clk   (clk),
      .addr  (word_addr),
      .we    (we[w]),
      .wdata (wdata),
      .rdata (rdata[w])
    );
  end

endmodule

`default_nettype wire

// File: verilog/tag_lookup.sv
`default_nettype none

module tag_lookup #(
  parameter int SETS       = 16,
  parameter int LINE_WORDS = 16
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [$clog2(SETS)-1:0]             index,
  input  logic [cache_pkg::ADDR_BITS-$clog2(SETS)-$clog2(LINE_WORDS)-3:0] lookup_tag,
  input  cache_pkg::way_t                     fill_way,
  input  logic                                fill_en,
  input  cache_pkg::way_t                     use_way,
  input  logic                                use_en,
  input  logic                                mark_dirty,
  output cache_pkg::way_mask_t                hit_mask,
  output cache_pkg::way_t                     victim_way,
  output logic [cache_pkg::ADDR_BITS-$clog2(SETS)-$clog2(LINE_WORDS)-3:0] victim_tag,
  output logic                                victim_dirty
);

  localparam int IDX_BITS = $clog2(SETS);
  localparam int OFF_BITS = $clog2(LINE_WORDS);
  localparam int TAG_BITS = cache_pkg::ADDR_BITS - IDX_BITS - OFF_BITS - 2;
  localparam int WAYS     = cache_pkg::WAYS;

  typedef logic [TAG_BITS-1:0] tag_t;

  typedef struct packed {
    tag_t tag;
    logic valid;
    logic dirty;
  } tag_entry_t;

  tag_t                 tag_rd [WAYS];
  tag_entry_t           entry  [WAYS];
  logic [IDX_BITS-1:0]  idx_q;
  cache_pkg::way_mask_t valid_r [SETS];
  cache_pkg::way_mask_t dirty_r [SETS];
  cache_pkg::age_t      age_r   [SETS][WAYS];

  ////////////////////////////////////////
  // Tag RAMs, one per way
  ////////////////////////////////////////

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    cache_ram #(
      .DEPTH   (SETS),
      .ENTRY_T (tag_t)
    ) u_tag_ram (
      .clk   (clk),
      .addr  (index),
      .we    (fill_en && (fill_way == w)),
      .wdata (lookup_tag),
      .rdata (tag_rd[w])
    );

    assign entry[w]    = '{tag: tag_rd[w], valid: valid_r[idx_q][w], dirty: dirty_r[idx_q][w]};
    assign hit_mask[w] = entry[w].valid && (entry[w].tag == lookup_tag);
  end

  // Victim: first invalid way, else oldest, low way wins a tie
  always_comb
  begin
    logic found;
    found      = 1'b0;
    victim_way = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (!found && !entry[w].valid)
      begin
        victim_way = cache_pkg::way_t'(w);
        found      = 1'b1;
      end
    end
    if (!found)
    begin
      for (int w = 1; w < WAYS; w++)
      begin
        if (age_r[idx_q][w] > age_r[idx_q][victim_way])
          victim_way = cache_pkg::way_t'(w);
      end
    end
  end

  assign victim_tag   = entry[victim_way].tag;
  assign victim_dirty = entry[victim_way].dirty;

  ////////////////////////////////////////
  // Line state
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      idx_q <= '0;
      for (int s = 0; s < SETS; s++)
      begin
        valid_r[s] <= '0;
        dirty_r[s] <= '0;
        for (int w = 0; w < WAYS; w++)
          age_r[s][w] <= '0;
      end
    end
    else
    begin
      idx_q <= index;
      if (fill_en)
      begin
        valid_r[index][fill_way] <= 1'b1;
        dirty_r[index][fill_way] <= 1'b0;
      end
      if (use_en)
      begin
        for (int w = 0; w < WAYS; w++)
        begin
          if (w == use_way)
            age_r[index][w] <= '0;
          else if (age_r[index][w] <= age_r[index][use_way])
            age_r[index][w] <= age_r[index][w] + 1'b1;  // Not older than the used way
        end
        if (mark_dirty)
          dirty_r[index][use_way] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/cache_ram.sv
`default_nettype none

// Single port RAM, registered read
module cache_ram #(
  parameter int  DEPTH   = 16,
  parameter type ENTRY_T = logic [31:0]
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic                     we,
  input  ENTRY_T                   wdata,
  output ENTRY_T                   rdata
);

  ENTRY_T mem [DEPTH];

  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];  // Old data on a write
  end

endmodule

`default_nettype wire

// File: verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

  ////////////////////////////////////////
  // CPU side
  ////////////////////////////////////////

  typedef struct packed {
    logic                                  valid;
    logic                                  write;
    logic [cache_pkg::ADDR_BITS-1:0]       addr;
    cache_pkg::word_t                      wdata;
    cache_pkg::be_t                        be;
  } cpu_req_t;

  typedef struct packed {
    logic             ok;    // One cycle per request
    cache_pkg::word_t rdata;
  } cpu_rsp_t;

  ////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////

  typedef struct packed {
    logic                            rd;    // Held until addr_ok
    logic                            wr;    // High for the whole write burst
    logic [cache_pkg::ADDR_BITS-1:0] addr;  // Line aligned
    cache_pkg::word_t                wdata;
  } mem_req_t;

  typedef struct packed {
    logic             addr_ok;
    logic             rdata_ok;
    logic             wdata_ok;
    cache_pkg::word_t rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

  ////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////

  localparam int WAYS      = 4;
  localparam int WORD_BITS = 32;
  localparam int ADDR_BITS = 32;

  ////////////////////////////////////////
  // Common types
  ////////////////////////////////////////

  typedef logic [WORD_BITS-1:0] word_t;

  // Bit 3 enables the top byte
  typedef logic [WORD_BITS/8-1:0] be_t;

  typedef logic [$clog2(WAYS)-1:0] way_t;

  typedef logic [WAYS-1:0] way_mask_t;

  // Replacement age, zero is most recent
  typedef logic [1:0] age_t;

endpackage

`default_nettype wire
